// ==== design/ipv4_pkg.sv ====
package ipv4_pkg;

  //////////////////////////////////////////////////////////////////////
  // Protocol constants
  //////////////////////////////////////////////////////////////////////

  localparam int          IPV4_HDR_LEN   = 20;       // No options supported
  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;

  typedef logic [31:0] ipv4_addr_t;
  typedef logic [47:0] mac_addr_t;

  localparam ipv4_addr_t IPV4_BROADCAST = 32'hffff_ffff;

  //////////////////////////////////////////////////////////////////////
  // Header and stream types
  //////////////////////////////////////////////////////////////////////

  // Fixed 20-byte header, fields in wire order
  typedef struct packed {
    logic [3:0]  ver;
    logic [3:0]  ihl;    // Header length in 32-bit words
    logic [7:0]  qos;
    logic [15:0] length; // Header plus payload in bytes
    logic [15:0] id;
    logic [1:0]  df;     // Upper bit is the reserved flag
    logic        mf;
    logic [12:0] fo;
    logic [7:0]  ttl;
    logic [7:0]  proto;
    logic [15:0] chsum;
    ipv4_addr_t  src_ip;
    ipv4_addr_t  dst_ip;
  } ipv4_hdr_t;

  typedef struct packed {
    logic [7:0] dat;
    logic       val;
    logic       sof;
    logic       eof;
    logic       err;
  } byte_stream_t;

  typedef struct packed {
    mac_addr_t  mac_addr;
    ipv4_addr_t ipv4_addr;
  } dev_t;

  // Ethernet header fields beside a MAC stream
  typedef struct packed {
    mac_addr_t   dst_mac;
    mac_addr_t   src_mac;
    logic [15:0] ethertype;
  } eth_meta_t;

  //////////////////////////////////////////////////////////////////////
  // Transmit source handshake
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic      rdy;       // Held with a stable header until done
    logic      broadcast; // Skip ARP, send to all-ones MAC
    ipv4_hdr_t hdr;
  } src_offer_t;

  typedef struct packed {
    logic req;  // Send payload now
    logic busy;
    logic done;
  } src_ctrl_t;

  // FSM encodings
  typedef enum logic [1:0] {
    rx_idle,
    rx_hdr,
    rx_payload,
    rx_drop
  } rx_state_t;

  typedef enum logic [2:0] {
    tx_idle,
    tx_calc,
    tx_arp,
    tx_hdr,
    tx_payload,
    tx_done
  } tx_state_t;

endpackage

// ==== design/ipv4_hdr_chsum.sv ====
module ipv4_hdr_chsum (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic                start,
  input  ipv4_pkg::ipv4_hdr_t hdr,
  output logic [15:0]         chsum,
  output logic                done
);

  localparam int N_WORDS = ipv4_pkg::IPV4_HDR_LEN / 2;

  ipv4_pkg::ipv4_hdr_t hdr_clr;
  logic [159:0]        words;    // Shifts one 16-bit word out per cycle
  logic [19:0]         acc;      // Room for ten word carries
  logic [16:0]         fold1;
  logic [15:0]         fold2;
  logic [3:0]          word_cnt;
  logic                run;

  // Checksum field counts as zero
  always_comb begin
    hdr_clr       = hdr;
    hdr_clr.chsum = '0;
  end

  assign fold1 = {1'b0, acc[15:0]} + {13'd0, acc[19:16]};
  assign fold2 = fold1[15:0] + {15'd0, fold1[16]};
  assign chsum = ~fold2;

  ///////////////////////////////////////////////////////////////////////
  // Sequencing
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      run      <= 1'b0;
      done     <= 1'b0;
      word_cnt <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        run      <= 1'b1;
        word_cnt <= '0;
      end else if (run) begin
        word_cnt <= word_cnt + 4'd1;
        if (word_cnt == 4'(N_WORDS - 1)) begin
          run  <= 1'b0;
          done <= 1'b1; // Single pulse, chsum holds after it
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      words <= hdr_clr;
      acc   <= '0;
    end else if (run) begin
      acc   <= acc + {4'd0, words[159:144]};
      words <= {words[143:0], 16'd0};
    end
  end

endmodule

// ==== design/ipv4_rx_parser.sv ====
module ipv4_rx_parser (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  ipv4_pkg::dev_t         dev,
  input  ipv4_pkg::byte_stream_t mac_rx,
  input  ipv4_pkg::eth_meta_t    mac_rx_meta,
  output ipv4_pkg::byte_stream_t ipv4_rx,
  output ipv4_pkg::ipv4_hdr_t    ipv4_rx_hdr
);

  ipv4_pkg::rx_state_t state;
  ipv4_pkg::ipv4_hdr_t hdr_sr;
  ipv4_pkg::ipv4_hdr_t hdr_next;
  logic [15:0]         byte_cnt;  // Index of the incoming byte within the packet
  logic [19:0]         sum;
  logic [7:0]          sum_hi;
  logic [16:0]         fold1;
  logic [15:0]         fold2;
  logic                err_seen;
  logic                hdr_bad;
  logic                addr_hit;
  logic                last_pay;

  assign hdr_next = {hdr_sr[151:0], mac_rx.dat};
  assign addr_hit = (hdr_next.dst_ip == dev.ipv4_addr) ||
                    (hdr_next.dst_ip == ipv4_pkg::IPV4_BROADCAST);

  // Fold carries back in, a good header sums to all ones
  assign fold1    = {1'b0, sum[15:0]} + {13'd0, sum[19:16]};
  assign fold2    = fold1[15:0] + {15'd0, fold1[16]};
  assign hdr_bad  = (fold2 != 16'hffff) || (ipv4_rx_hdr.ihl != 4'd5) || err_seen;
  assign last_pay = byte_cnt == ipv4_rx_hdr.length - 16'd1;

  always_ff @(posedge clk) begin
    ipv4_rx.dat <= mac_rx.dat; // One cycle through
    if (fsm_rst) begin
      state       <= ipv4_pkg::rx_idle;
      byte_cnt    <= '0;
      err_seen    <= 1'b0;
      ipv4_rx.val <= 1'b0;
      ipv4_rx.sof <= 1'b0;
      ipv4_rx.eof <= 1'b0;
      ipv4_rx.err <= 1'b0;
    end else begin
      ipv4_rx.val <= 1'b0;
      ipv4_rx.sof <= 1'b0;
      ipv4_rx.eof <= 1'b0;
      ipv4_rx.err <= 1'b0;
      case (state)
        ipv4_pkg::rx_idle: begin
          if (mac_rx.val && mac_rx.sof &&
              mac_rx_meta.ethertype == ipv4_pkg::ETHERTYPE_IPV4) begin
            hdr_sr   <= hdr_next;
            sum      <= '0;
            sum_hi   <= mac_rx.dat; // Byte 0 is a high byte
            byte_cnt <= 16'd1;
            err_seen <= mac_rx.err;
            state    <= ipv4_pkg::rx_hdr;
          end
        end
        ipv4_pkg::rx_hdr: begin
          if (mac_rx.val) begin
            hdr_sr   <= hdr_next;
            byte_cnt <= byte_cnt + 16'd1;
            err_seen <= err_seen | mac_rx.err;
            if (byte_cnt[0]) sum <= sum + {4'd0, sum_hi, mac_rx.dat};
            else sum_hi <= mac_rx.dat;
            if (mac_rx.eof) begin
              state <= ipv4_pkg::rx_idle; // Runt frame
            end else if (byte_cnt == 16'(ipv4_pkg::IPV4_HDR_LEN - 1)) begin
              ipv4_rx_hdr <= hdr_next;
              if (addr_hit && hdr_next.length > 16'(ipv4_pkg::IPV4_HDR_LEN))
                state <= ipv4_pkg::rx_payload;
              else
                state <= ipv4_pkg::rx_drop;
            end
          end
        end
        ipv4_pkg::rx_payload: begin
          if (mac_rx.val) begin
            byte_cnt    <= byte_cnt + 16'd1;
            ipv4_rx.val <= 1'b1;
            ipv4_rx.sof <= byte_cnt == 16'(ipv4_pkg::IPV4_HDR_LEN);
            if (last_pay || mac_rx.eof) begin
              ipv4_rx.eof <= 1'b1;
              // Short frame also counts as an error
              ipv4_rx.err <= hdr_bad || mac_rx.err || !last_pay;
              state       <= mac_rx.eof ? ipv4_pkg::rx_idle : ipv4_pkg::rx_drop;
            end
          end
        end
        ipv4_pkg::rx_drop: begin
          if (mac_rx.val && mac_rx.eof) state <= ipv4_pkg::rx_idle; // Padding or foreign
        end
        default: state <= ipv4_pkg::rx_idle;
      endcase
    end
  end

  a_rx_flags_need_val : assert property (@(posedge clk) disable iff (fsm_rst)
    (ipv4_rx.sof || ipv4_rx.eof) |-> ipv4_rx.val)
    else $error("ipv4_rx sof or eof without val");

  a_rx_hdr_stable : assert property (@(posedge clk) disable iff (fsm_rst)
    (ipv4_rx.val && !ipv4_rx.sof) |-> $stable(ipv4_rx_hdr))
    else $error("ipv4_rx_hdr changed inside a packet");

endmodule

// ==== design/ipv4_tx_framer.sv ====
module ipv4_tx_framer (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  ipv4_pkg::dev_t         dev,
  input  ipv4_pkg::src_offer_t   offer,
  input  ipv4_pkg::byte_stream_t pay,
  output ipv4_pkg::src_ctrl_t    ctrl,
  output ipv4_pkg::byte_stream_t mac_tx,
  output ipv4_pkg::eth_meta_t    mac_tx_meta,
  output ipv4_pkg::ipv4_addr_t   arp_ipv4,
  input  ipv4_pkg::mac_addr_t    arp_mac,
  input  logic                   arp_val,
  input  logic                   arp_err
);

  ipv4_pkg::tx_state_t state;
  ipv4_pkg::ipv4_hdr_t hdr_q;      // Latched header, later shifted out
  ipv4_pkg::mac_addr_t dst_mac;
  logic [15:0]         chsum;
  logic                chsum_done;
  logic                chsum_start;
  logic                bcast;
  logic [4:0]          hdr_cnt;

  assign chsum_start = (state == ipv4_pkg::tx_idle) && offer.rdy;

  ipv4_hdr_chsum i_chsum (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .start   (chsum_start),
    .hdr     (offer.hdr),
    .chsum   (chsum),
    .done    (chsum_done)
  );

  assign mac_tx_meta = '{dst_mac: dst_mac, src_mac: dev.mac_addr,
                         ethertype: ipv4_pkg::ETHERTYPE_IPV4};

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state      <= ipv4_pkg::tx_idle;
      ctrl       <= '0;
      hdr_cnt    <= '0;
      mac_tx.val <= 1'b0;
      mac_tx.sof <= 1'b0;
      mac_tx.eof <= 1'b0;
      mac_tx.err <= 1'b0;
    end else begin
      mac_tx.val <= 1'b0;
      mac_tx.sof <= 1'b0;
      mac_tx.eof <= 1'b0;
      mac_tx.err <= 1'b0;
      ctrl.done  <= 1'b0;
      case (state)
        ipv4_pkg::tx_idle: begin
          if (offer.rdy) begin
            hdr_q     <= offer.hdr;
            bcast     <= offer.broadcast;
            arp_ipv4  <= offer.hdr.dst_ip; // Lookup runs during the checksum
            ctrl.busy <= 1'b1;
            state     <= ipv4_pkg::tx_calc;
          end
        end
        ipv4_pkg::tx_calc: begin
          if (chsum_done) begin
            hdr_q.chsum <= chsum;
            state       <= ipv4_pkg::tx_arp;
          end
        end
        ipv4_pkg::tx_arp: begin
          hdr_cnt <= '0;
          if (bcast) begin
            dst_mac <= '1;
            state   <= ipv4_pkg::tx_hdr;
          end else if (arp_err) begin
            ctrl.done <= 1'b1; // Nothing goes out
            state     <= ipv4_pkg::tx_done;
          end else if (arp_val) begin
            dst_mac <= arp_mac;
            state   <= ipv4_pkg::tx_hdr;
          end
        end
        ipv4_pkg::tx_hdr: begin
          mac_tx.dat <= hdr_q[159:152];
          mac_tx.val <= 1'b1;
          mac_tx.sof <= hdr_cnt == 5'd0;
          hdr_q      <= {hdr_q[151:0], 8'd0};
          hdr_cnt    <= hdr_cnt + 5'd1;
          if (hdr_cnt == 5'(ipv4_pkg::IPV4_HDR_LEN - 1)) begin
            ctrl.req <= 1'b1; // Source starts its payload
            state    <= ipv4_pkg::tx_payload;
          end
        end
        ipv4_pkg::tx_payload: begin
          mac_tx.dat <= pay.dat;
          mac_tx.val <= pay.val;
          mac_tx.eof <= pay.val && pay.eof;
          mac_tx.err <= pay.val && pay.err;
          if (pay.val && pay.eof) begin
            ctrl.req  <= 1'b0;
            ctrl.done <= 1'b1;
            state     <= ipv4_pkg::tx_done;
          end
        end
        ipv4_pkg::tx_done: begin
          ctrl.busy <= 1'b0;
          state     <= ipv4_pkg::tx_idle;
        end
        default: state <= ipv4_pkg::tx_idle;
      endcase
    end
  end

  a_sof_in_hdr : assert property (@(posedge clk) disable iff (fsm_rst)
    mac_tx.sof |-> state == ipv4_pkg::tx_hdr)
    else $error("mac_tx sof outside header serialization");

endmodule

// ==== design/ipv4_tx_arbiter.sv ====
module ipv4_tx_arbiter #(
  parameter int N_SRC = 3
) (
  input  logic                               clk,
  input  logic                               fsm_rst,
  input  ipv4_pkg::src_offer_t   [N_SRC-1:0] src_offer,
  input  ipv4_pkg::byte_stream_t [N_SRC-1:0] src_tx,
  output ipv4_pkg::src_ctrl_t    [N_SRC-1:0] src_ctrl,
  output ipv4_pkg::src_offer_t               offer,
  output ipv4_pkg::byte_stream_t             pay,
  input  ipv4_pkg::src_ctrl_t                ctrl
);

  localparam int SEL_W = (N_SRC > 1) ? $clog2(N_SRC) : 1;

  logic [N_SRC-1:0] rdy_vec;
  logic [N_SRC-1:0] rdy_lat;  // Frozen while a grant is active
  logic [N_SRC-1:0] gnt;
  logic [N_SRC-1:0] req_vec;
  logic [SEL_W-1:0] sel;
  logic             active;
  logic             cool;     // Finished source still shows rdy this cycle

  // Highest set bit wins
  always_comb begin
    sel = '0;
    for (int i = 0; i < N_SRC; i++) begin
      rdy_vec[i] = src_offer[i].rdy;
      req_vec[i] = src_ctrl[i].req;
      if (rdy_lat[i]) sel = SEL_W'(i);
    end
  end

  always_comb begin
    for (int i = 0; i < N_SRC; i++) gnt[i] = active && (sel == SEL_W'(i));
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      active  <= 1'b0;
      cool    <= 1'b0;
      rdy_lat <= '0;
    end else begin
      cool <= ctrl.done;
      if (!active) begin
        rdy_lat <= rdy_vec;
        active  <= |rdy_vec && !cool;
      end else if (ctrl.done) begin
        active <= 1'b0;
      end
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Selected source toward the framer, control back to the source
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    offer.hdr       <= src_offer[sel].hdr;
    offer.broadcast <= src_offer[sel].broadcast;
    pay.dat         <= src_tx[sel].dat;
    if (fsm_rst) begin
      offer.rdy <= 1'b0;
      pay.val   <= 1'b0;
      pay.sof   <= 1'b0;
      pay.eof   <= 1'b0;
      pay.err   <= 1'b0;
      src_ctrl  <= '0;
    end else begin
      offer.rdy <= active && !ctrl.done && src_offer[sel].rdy;
      pay.val   <= active && src_tx[sel].val;
      pay.sof   <= active && src_tx[sel].sof;
      pay.eof   <= active && src_tx[sel].eof;
      pay.err   <= active && src_tx[sel].err;
      for (int i = 0; i < N_SRC; i++) src_ctrl[i] <= gnt[i] ? ctrl : '0;
    end
  end

  a_one_req : assert property (@(posedge clk) disable iff (fsm_rst)
    $onehot0(req_vec))
    else $error("more than one source sees req");

endmodule

// ==== design/ipv4_top.sv ====
module ipv4_top #(
  parameter int N_SRC = 3
) (
  input  logic                               clk,
  input  logic                               fsm_rst,
  input  ipv4_pkg::dev_t                     dev,
  // Receive side
  input  ipv4_pkg::byte_stream_t             mac_rx,
  input  ipv4_pkg::eth_meta_t                mac_rx_meta,
  output ipv4_pkg::byte_stream_t             ipv4_rx,
  output ipv4_pkg::ipv4_hdr_t                ipv4_rx_hdr,
  // Transmit sources
  input  ipv4_pkg::src_offer_t   [N_SRC-1:0] src_offer,
  input  ipv4_pkg::byte_stream_t [N_SRC-1:0] src_tx,
  output ipv4_pkg::src_ctrl_t    [N_SRC-1:0] src_ctrl,
  // MAC transmit side
  output ipv4_pkg::byte_stream_t             mac_tx,
  output ipv4_pkg::eth_meta_t                mac_tx_meta,
  // ARP table
  output ipv4_pkg::ipv4_addr_t               arp_ipv4,
  input  ipv4_pkg::mac_addr_t                arp_mac,
  input  logic                               arp_val,
  input  logic                               arp_err
);

  ipv4_pkg::src_offer_t   arb_offer;
  ipv4_pkg::byte_stream_t arb_pay;
  ipv4_pkg::src_ctrl_t    tx_ctrl;

  ipv4_rx_parser i_rx_parser (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .dev         (dev),
    .mac_rx      (mac_rx),
    .mac_rx_meta (mac_rx_meta),
    .ipv4_rx     (ipv4_rx),
    .ipv4_rx_hdr (ipv4_rx_hdr)
  );

  ipv4_tx_arbiter #(
    .N_SRC (N_SRC)
  ) i_tx_arbiter (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .src_offer (src_offer),
    .src_tx    (src_tx),
    .src_ctrl  (src_ctrl),
    .offer     (arb_offer),
    .pay       (arb_pay),
    .ctrl      (tx_ctrl)
  );

  ipv4_tx_framer i_tx_framer (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .dev         (dev),
    .offer       (arb_offer),
    .pay         (arb_pay),
    .ctrl        (tx_ctrl),
    .mac_tx      (mac_tx),
    .mac_tx_meta (mac_tx_meta),
    .arp_ipv4    (arp_ipv4),
    .arp_mac     (arp_mac),
    .arp_val     (arp_val),
    .arp_err     (arp_err)
  );

endmodule

// ==== testbench/ipv4_tb.sv ====
module ipv4_tb;

  localparam int N_SRC        = 3;
  localparam int MAX_PAY      = 18;  // Longest payload used below
  localparam int N_FRAMES     = 9;
  localparam int FRAME_CYC    = 2 * (ipv4_pkg::IPV4_HDR_LEN + MAX_PAY) + 40;
  localparam int WATCHDOG_CYC = N_FRAMES * FRAME_CYC + 20;

  localparam ipv4_pkg::mac_addr_t  DEV_MAC    = 48'h02_00_5e_00_00_01;
  localparam ipv4_pkg::ipv4_addr_t DEV_IP     = 32'hc0a8_0105;
  localparam ipv4_pkg::ipv4_addr_t OTHER_IP   = 32'hc0a8_0109;
  localparam ipv4_pkg::ipv4_addr_t PEER_IP    = 32'hc0a8_010f; // Slow ARP answer
  localparam ipv4_pkg::ipv4_addr_t PEER2_IP   = 32'hc0a8_0122;
  localparam ipv4_pkg::ipv4_addr_t UNKNOWN_IP = 32'hc0a8_01ee; // Not in the ARP table

  logic                               clk = 1'b0;
  logic                               fsm_rst;
  ipv4_pkg::dev_t                     dev;
  ipv4_pkg::byte_stream_t             mac_rx;
  ipv4_pkg::eth_meta_t                mac_rx_meta;
  ipv4_pkg::byte_stream_t             ipv4_rx;
  ipv4_pkg::ipv4_hdr_t                ipv4_rx_hdr;
  ipv4_pkg::src_offer_t   [N_SRC-1:0] src_offer;
  ipv4_pkg::byte_stream_t [N_SRC-1:0] src_tx = '0;
  ipv4_pkg::src_ctrl_t    [N_SRC-1:0] src_ctrl;
  ipv4_pkg::byte_stream_t             mac_tx;
  ipv4_pkg::eth_meta_t                mac_tx_meta;
  ipv4_pkg::ipv4_addr_t               arp_ipv4;
  ipv4_pkg::mac_addr_t                arp_mac = '0;
  logic                               arp_val = 1'b0;
  logic                               arp_err = 1'b0;

  logic [15:0]          lfsr = 16'd56580;
  string                test_name = "reset";
  int                   chk_err = 0;
  int                   tmo_err = 0;
  ipv4_pkg::ipv4_addr_t arp_seen = '0;
  int                   arp_delay = 0;

  // Receive side expectations
  logic [7:0]          rx_exp [0:63];
  ipv4_pkg::ipv4_hdr_t rx_exp_hdr;
  logic                rx_exp_err = 1'b0;
  logic                rx_fwd = 1'b0;
  int                  rx_len = 0;
  int                  rx_start = 0;
  int                  rx_cnt = 0;   // All forwarded bytes so far
  int                  rx_idx;
  logic [9:0]          rx_got;
  logic [9:0]          rx_want;

  // Transmit side expectations, {sof, eof, dat} per byte
  logic [9:0]          tx_exp [0:127];
  int                  tx_exp_src [0:127];
  ipv4_pkg::eth_meta_t tx_exp_meta [0:127];
  int                  tx_total = 0;
  int                  tx_start = 0;
  int                  tx_cnt = 0;
  int                  tx_idx;
  int                  tx_owner;
  logic [9:0]          tx_got;
  logic [9:0]          tx_want;

  // Source models
  logic [7:0] src_pay [N_SRC][64];
  int         src_len [N_SRC] = '{default: 0};
  int         src_pos [N_SRC] = '{default: 0};
  logic       src_held [N_SRC] = '{default: 1'b0};

  ipv4_top #(
    .N_SRC (N_SRC)
  ) i_dut (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .dev         (dev),
    .mac_rx      (mac_rx),
    .mac_rx_meta (mac_rx_meta),
    .ipv4_rx     (ipv4_rx),
    .ipv4_rx_hdr (ipv4_rx_hdr),
    .src_offer   (src_offer),
    .src_tx      (src_tx),
    .src_ctrl    (src_ctrl),
    .mac_tx      (mac_tx),
    .mac_tx_meta (mac_tx_meta),
    .arp_ipv4    (arp_ipv4),
    .arp_mac     (arp_mac),
    .arp_val     (arp_val),
    .arp_err     (arp_err)
  );

  always #50 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Reference models
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic [15:0] ref_chsum(input ipv4_pkg::ipv4_hdr_t h);
    logic [159:0] w;
    logic [31:0]  s;
    h.chsum = '0;
    w       = h;
    s       = '0;
    for (int i = 0; i < 10; i++) s = s + w[159 - 16*i -: 16];
    while (s[31:16] != 0) s = s[15:0] + s[31:16]; // End-around carry
    return ~s[15:0];
  endfunction

  function automatic ipv4_pkg::ipv4_hdr_t make_hdr(input ipv4_pkg::ipv4_addr_t dst,
                                                  input int len);
    ipv4_pkg::ipv4_hdr_t h;
    h        = '0;
    h.ver    = 4'd4;
    h.ihl    = 4'd5;
    h.qos    = 8'(rand_bits(8));
    h.length = 16'(ipv4_pkg::IPV4_HDR_LEN + len);
    h.id     = 16'(rand_bits(16));
    h.ttl    = 8'(rand_bits(8));
    h.proto  = 8'(rand_bits(8));
    h.src_ip = rand_bits(32);
    h.dst_ip = dst;
    h.chsum  = ref_chsum(h);
    return h;
  endfunction

  function automatic ipv4_pkg::mac_addr_t arp_lookup(input ipv4_pkg::ipv4_addr_t ip);
    return {16'h02a0, ip};
  endfunction

  function automatic void add_tx(input logic [7:0] dat, input logic sof, input logic eof,
                                 input int src);
    tx_exp[tx_total]     = {sof, eof, dat};
    tx_exp_src[tx_total] = src;
    tx_total++;
  endfunction

  // ARP table with an address dependent latency
  always @(negedge clk) begin
    if (arp_ipv4 !== arp_seen) begin
      arp_seen  = arp_ipv4;
      arp_val   = 1'b0;
      arp_err   = 1'b0;
      arp_delay = 8 + int'(arp_ipv4[3:0]);
    end else if (arp_delay > 0) begin
      arp_delay--;
    end else if (!$isunknown(arp_ipv4) && arp_ipv4 != ipv4_pkg::IPV4_BROADCAST) begin
      arp_mac = arp_lookup(arp_ipv4);
      arp_val = arp_ipv4 != UNKNOWN_IP;
      arp_err = arp_ipv4 == UNKNOWN_IP;
    end
  end

  // Sources send on req, pausing once before bytes with the top bit set
  always @(negedge clk) begin
    for (int i = 0; i < N_SRC; i++) begin
      src_tx[i] = '0;
      if (src_ctrl[i].done) begin
        src_pos[i] = 0;
      end else if (src_ctrl[i].req && src_pos[i] < src_len[i]) begin
        if (src_pay[i][src_pos[i]][7] && !src_held[i]) begin
          src_held[i] = 1'b1;
        end else begin
          src_tx[i] = '{dat: src_pay[i][src_pos[i]], val: 1'b1, sof: src_pos[i] == 0,
                        eof: src_pos[i] == src_len[i] - 1, err: 1'b0};
          src_pos[i]++;
          src_held[i] = 1'b0;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Monitors and checks
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (ipv4_rx.val) rx_cnt <= rx_cnt + 1;
    if (mac_tx.val) tx_cnt <= tx_cnt + 1;
  end

  assign rx_idx   = rx_cnt - rx_start;
  assign rx_got   = {ipv4_rx.sof, ipv4_rx.eof, ipv4_rx.dat};
  assign rx_want  = {rx_idx == 0, rx_idx == rx_len - 1, rx_exp[rx_idx]};
  assign tx_idx   = tx_cnt - tx_start;
  assign tx_got   = {mac_tx.sof, mac_tx.eof, mac_tx.dat};
  assign tx_want  = tx_exp[tx_idx];
  assign tx_owner = (tx_idx > 0) ? tx_exp_src[tx_idx - 1] : -1; // Frame on the wire

  a_rx_data : assert property (@(posedge clk) disable iff (fsm_rst)
    ipv4_rx.val |-> rx_got == rx_want)
    else begin
      chk_err++;
      $display("FAIL %s rx byte: expected %h, actual %h", test_name,
               $sampled(rx_want), $sampled(rx_got));
    end

  a_rx_hdr : assert property (@(posedge clk) disable iff (fsm_rst)
    ipv4_rx.val |-> ipv4_rx_hdr == rx_exp_hdr)
    else begin
      chk_err++;
      $display("FAIL %s rx header: expected %h, actual %h", test_name,
               $sampled(rx_exp_hdr), $sampled(ipv4_rx_hdr));
    end

  a_rx_filter : assert property (@(posedge clk) disable iff (fsm_rst)
    ipv4_rx.val |-> rx_fwd)
    else begin
      chk_err++;
      $display("In %s a frame for another address was forwarded", test_name);
    end

  a_rx_err : assert property (@(posedge clk) disable iff (fsm_rst)
    (ipv4_rx.val && ipv4_rx.eof) |-> ipv4_rx.err == rx_exp_err)
    else begin
      chk_err++;
      $display("FAIL %s rx err: expected %b, actual %b", test_name,
               $sampled(rx_exp_err), $sampled(ipv4_rx.err));
    end

  a_tx_extra : assert property (@(posedge clk) disable iff (fsm_rst)
    mac_tx.val |-> tx_idx < tx_total)
    else begin
      chk_err++;
      $display("In %s mac_tx sent more bytes than expected", test_name);
    end

  a_tx_data : assert property (@(posedge clk) disable iff (fsm_rst)
    (mac_tx.val && tx_idx < tx_total) |-> tx_got == tx_want)
    else begin
      chk_err++;
      $display("FAIL %s tx byte: expected %h, actual %h", test_name,
               $sampled(tx_want), $sampled(tx_got));
    end

  // Sources never flag errors, so none may reach the MAC
  a_tx_err : assert property (@(posedge clk) disable iff (fsm_rst)
    mac_tx.val |-> !mac_tx.err)
    else begin
      chk_err++;
      $display("FAIL %s tx err: expected %b, actual %b", test_name,
               1'b0, $sampled(mac_tx.err));
    end

  a_tx_meta : assert property (@(posedge clk) disable iff (fsm_rst)
    (mac_tx.val && mac_tx.sof) |-> mac_tx_meta == tx_exp_meta[tx_idx])
    else begin
      chk_err++;
      $display("FAIL %s tx meta: expected %h, actual %h", test_name,
               $sampled(tx_exp_meta[tx_idx]), $sampled(mac_tx_meta));
    end

  for (genvar g = 0; g < N_SRC; g++) begin : g_owner
    a_req_owner : assert property (@(posedge clk) disable iff (fsm_rst)
      src_ctrl[g].req |-> tx_owner == g)
      else begin
        chk_err++;
        $display("FAIL %s req owner: expected %0d, actual %0d", test_name,
                 $sampled(tx_owner), g);
      end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic drive_rx(input logic [7:0] dat, input logic sof, input logic eof);
    mac_rx = '{dat: dat, val: 1'b1, sof: sof, eof: eof, err: 1'b0};
    @(negedge clk);
  endtask

  task automatic send_rx(input ipv4_pkg::ipv4_hdr_t hdr, input int len, input logic fwd,
                         input logic bad);
    logic [159:0] bits;
    logic [7:0]   b;
    if (bad) hdr.chsum[7:0] = hdr.chsum[7:0] ^ 8'h21;
    bits       = hdr;
    rx_exp_hdr = hdr;
    rx_exp_err = bad;
    rx_fwd     = fwd;
    rx_len     = len;
    rx_start   = rx_cnt;
    for (int k = 0; k < ipv4_pkg::IPV4_HDR_LEN; k++) drive_rx(bits[159 - 8*k -: 8], k == 0, 1'b0);
    for (int k = 0; k < len; k++) begin
      b         = 8'(rand_bits(8));
      rx_exp[k] = b;
      drive_rx(b, 1'b0, k == len - 1);
    end
    mac_rx = '0;
    repeat (2) @(negedge clk);  // Payload trails by one cycle
    assert (rx_cnt - rx_start == (fwd ? len : 0))
      else begin
        chk_err++;
        $display("FAIL %s rx bytes: expected %0d, actual %0d", test_name,
                 fwd ? len : 0, rx_cnt - rx_start);
      end
  endtask

  task automatic offer_tx(input int src, input ipv4_pkg::ipv4_addr_t dst, input logic bcast,
                          input int len, input logic sent);
    ipv4_pkg::ipv4_hdr_t hdr;
    ipv4_pkg::ipv4_hdr_t sent_hdr;
    logic [159:0]        bits;
    hdr            = make_hdr(dst, len);
    hdr.chsum      = 16'(rand_bits(16)); // Framer ignores this field
    sent_hdr       = hdr;
    sent_hdr.chsum = ref_chsum(hdr);
    bits           = sent_hdr;
    src_len[src]   = len;
    for (int k = 0; k < len; k++) src_pay[src][k] = 8'(rand_bits(8));
    if (sent) begin
      tx_exp_meta[tx_total] = '{dst_mac: bcast ? '1 : arp_lookup(dst), src_mac: DEV_MAC,
                                ethertype: ipv4_pkg::ETHERTYPE_IPV4};
      for (int k = 0; k < ipv4_pkg::IPV4_HDR_LEN; k++) add_tx(bits[159 - 8*k -: 8], k == 0,
                                                             1'b0, src);
      for (int k = 0; k < len; k++) add_tx(src_pay[src][k], 1'b0, k == len - 1, src);
    end
    src_offer[src] = '{rdy: 1'b1, broadcast: bcast, hdr: hdr};
  endtask

  task automatic wait_done(input int src);
    int n;
    n = 0;
    while (!src_ctrl[src].done && n < 2 * FRAME_CYC) begin
      @(negedge clk);
      n++;
    end
    if (!src_ctrl[src].done) begin
      tmo_err++;
      $display("Timeout in %s, source %0d never got done", test_name, src);
    end
    src_offer[src].rdy = 1'b0;
    @(negedge clk);
  endtask

  task automatic start_tx_test(input string name);
    test_name = name;
    tx_start  = tx_cnt;
    tx_total  = 0;
  endtask

  task automatic check_tx_count();
    assert (tx_cnt - tx_start == tx_total)
      else begin
        chk_err++;
        $display("FAIL %s tx bytes: expected %0d, actual %0d", test_name, tx_total,
                 tx_cnt - tx_start);
      end
  endtask

  initial begin
    fsm_rst     = 1'b1;
    dev         = '{mac_addr: DEV_MAC, ipv4_addr: DEV_IP};
    mac_rx      = '0;
    mac_rx_meta = '{dst_mac: DEV_MAC, src_mac: 48'h02_00_5e_00_00_42,
                    ethertype: ipv4_pkg::ETHERTYPE_IPV4};
    src_offer   = '0;
    repeat (5) @(negedge clk);
    fsm_rst = 1'b0;
    assert (!ipv4_rx.val && !mac_tx.val && src_ctrl == '0)
      else begin
        chk_err++;
        $display("Outputs were not idle after reset");
      end

    test_name = "unicast_rx";
    send_rx(make_hdr(DEV_IP, 16), 16, 1'b1, 1'b0);
    test_name = "filter_other";
    send_rx(make_hdr(OTHER_IP, 12), 12, 1'b0, 1'b0);
    test_name = "filter_bcast";
    send_rx(make_hdr(ipv4_pkg::IPV4_BROADCAST, 9), 9, 1'b1, 1'b0);
    test_name = "bad_chsum";
    send_rx(make_hdr(DEV_IP, 10), 10, 1'b1, 1'b1);

    start_tx_test("unicast_tx");
    offer_tx(0, PEER_IP, 1'b0, MAX_PAY, 1'b1);
    wait_done(0);
    check_tx_count();
    start_tx_test("broadcast_tx");
    offer_tx(1, ipv4_pkg::IPV4_BROADCAST, 1'b1, 8, 1'b1);
    wait_done(1);
    check_tx_count();
    start_tx_test("arp_fail");
    offer_tx(1, UNKNOWN_IP, 1'b0, 8, 1'b0);
    wait_done(1);
    check_tx_count();
    start_tx_test("arbitration");      // Highest index goes first
    offer_tx(2, PEER2_IP, 1'b0, 14, 1'b1);
    offer_tx(0, PEER_IP, 1'b0, 11, 1'b1);
    wait_done(2);
    wait_done(0);
    check_tx_count();

    $display("Errors: %0d check failures, %0d timeouts", chk_err, tmo_err);
    if (chk_err == 0 && tmo_err == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYC * 100);
    $display("Watchdog expired after %0d cycles", WATCHDOG_CYC);
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== sim.f ====
design/ipv4_pkg.sv
design/ipv4_hdr_chsum.sv
design/ipv4_rx_parser.sv
design/ipv4_tx_framer.sv
design/ipv4_tx_arbiter.sv
design/ipv4_top.sv
testbench/ipv4_tb.sv

// ==== Bender.yml ====
package:
  name: ipv4_stack

sources:
  - files:
      - design/ipv4_pkg.sv
      - design/ipv4_hdr_chsum.sv
      - design/ipv4_rx_parser.sv
      - design/ipv4_tx_framer.sv
      - design/ipv4_tx_arbiter.sv
      - design/ipv4_top.sv
  - target: simulation
    files:
      - testbench/ipv4_tb.sv
